/* verilog/seq_demo_pkg.sv */
package seq_demo_pkg;

    typedef logic [11:0] shift_word_t;   // Shift register contents.
    typedef logic [15:0] shift_count_t;  // Shift strobes since reset.
    typedef logic [ 7:0] hit_count_t;    // Detector hits.
    typedef logic [31:0] disp_word_t;    // Eight hex digits.
    typedef logic [ 6:0] seg_t;          // Segments a..g, active low.

    // Moore detector for overlapping 1-0-1.
    typedef enum logic [1:0] {
        S_IDLE,
        S_ONE,
        S_ONE_ZERO,
        S_HIT
    } moore_state_t;

    // Mealy detector for the same pattern, one state fewer.
    typedef enum logic [1:0] {
        M_IDLE,
        M_ONE,
        M_ONE_ZERO
    } mealy_state_t;

endpackage

/* verilog/stage_if.sv */
`timescale 1ns/10ps

// Shift stage output bundle.
interface shift_if import seq_demo_pkg::*; ();

    logic         strobe;       // One cycle, aligned with the new word.
    logic         new_bit;      // Same as word bit 0.
    shift_word_t  word;
    shift_count_t shift_count;

    modport src (
        output strobe,
        output new_bit,
        output word,
        output shift_count
    );

    modport dst (
        input strobe,
        input new_bit,
        input word,
        input shift_count
    );

endinterface

// Everything the display needs, in one bundle.
interface count_if import seq_demo_pkg::*; ();

    hit_count_t   moore_hits;
    hit_count_t   mealy_hits;
    shift_count_t shift_count;
    shift_word_t  word;

    modport src (
        output moore_hits,
        output mealy_hits,
        output shift_count,
        output word
    );

    modport dst (
        input moore_hits,
        input mealy_hits,
        input shift_count,
        input word
    );

endinterface

/* verilog/sync_and_debounce.sv */
`timescale 1ns/10ps

module sync_and_debounce #(
    parameter int W     = 1,
    parameter int DEPTH = 8
) (
    input  logic         clk,
    input  logic         i_arst_n,
    input  logic [W-1:0] i_in,
    output logic [W-1:0] o_out
);

    logic [W-1:0]     sync_q1;
    logic [W-1:0]     sync_q2;
    logic [DEPTH-1:0] stable_cnt [W];

    // Two-flop synchronizer.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= i_in;
            sync_q2 <= sync_q1;
        end
    end

    // A bit must differ from the held output for 2^DEPTH clocks
    // in a row before it is taken over.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_out <= '0;
            for (int i = 0; i < W; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < W; i++) begin
                if (sync_q2[i] == o_out[i]) begin
                    stable_cnt[i] <= '0;                    // Glitch, start over.
                end else if (&stable_cnt[i]) begin
                    o_out[i]      <= sync_q2[i];            // Saturated, adopt.
                    stable_cnt[i] <= '0;
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/strobe_gen.sv */
`timescale 1ns/10ps

module strobe_gen #(
    parameter int W = 23
) (
    input  logic clk,
    input  logic i_arst_n,
    output logic o_strobe
);

    logic [W-1:0] cnt;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;  // Wraps every 2^W cycles.
        end
    end

    // Pulse while the counter sits at all ones.
    assign o_strobe = &cnt;

endmodule

/* verilog/shift_stage.sv */
`timescale 1ns/10ps

module shift_stage import seq_demo_pkg::*; #(
    parameter int DEBOUNCE_DEPTH     = 8,
    parameter int SHIFT_STROBE_WIDTH = 23
) (
    input  logic        clk,
    input  logic        i_arst_n,
    input  logic        i_shift_bit,
    output shift_word_t o_led,
    shift_if.src        shift
);

    logic         bit_db;
    logic         shift_strobe;
    logic         strobe_d;
    shift_word_t  word;
    shift_count_t shift_count;

    sync_and_debounce #(
        .W     (1),
        .DEPTH (DEBOUNCE_DEPTH)
    ) u_bit_debounce (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_in     (i_shift_bit),
        .o_out    (bit_db)
    );

    strobe_gen #(
        .W (SHIFT_STROBE_WIDTH)
    ) u_shift_strobe (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .o_strobe (shift_strobe)
    );

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            word        <= '0;
            shift_count <= '0;
            strobe_d    <= 1'b0;
        end else begin
            strobe_d <= shift_strobe;  // Lines up with the updated word.
            if (shift_strobe) begin
                word        <= {word[$bits(word)-2:0], bit_db};  // Newest bit at 0.
                shift_count <= shift_count + 1'b1;
            end
        end
    end

    assign shift.strobe      = strobe_d;
    assign shift.new_bit     = word[0];
    assign shift.word        = word;
    assign shift.shift_count = shift_count;

    assign o_led = ~word;  // LEDs are active low.

endmodule

/* verilog/pattern_detect.sv */
`timescale 1ns/10ps

module pattern_detect import seq_demo_pkg::*; (
    input  logic clk,
    input  logic i_arst_n,
    shift_if.dst shift,
    count_if.src cnt
);

    moore_state_t moore_state;
    moore_state_t moore_next;
    mealy_state_t mealy_state;
    mealy_state_t mealy_next;
    logic         moore_out;
    logic         mealy_out;
    hit_count_t   moore_hits;
    hit_count_t   mealy_hits;

    // Moore next state; after a hit the final 1 counts as a fresh start.
    always_comb begin
        case (moore_state)
            S_IDLE:     moore_next = shift.new_bit ? S_ONE : S_IDLE;
            S_ONE:      moore_next = shift.new_bit ? S_ONE : S_ONE_ZERO;
            S_ONE_ZERO: moore_next = shift.new_bit ? S_HIT : S_IDLE;
            S_HIT:      moore_next = shift.new_bit ? S_ONE : S_ONE_ZERO;
            default:    moore_next = S_IDLE;
        endcase
    end

    assign moore_out = (moore_state == S_HIT);  // Output from state only.

    // Mealy next state.
    always_comb begin
        case (mealy_state)
            M_IDLE:     mealy_next = shift.new_bit ? M_ONE : M_IDLE;
            M_ONE:      mealy_next = shift.new_bit ? M_ONE : M_ONE_ZERO;
            M_ONE_ZERO: mealy_next = shift.new_bit ? M_ONE : M_IDLE;
            default:    mealy_next = M_IDLE;
        endcase
    end

    // Hit as soon as the closing 1 arrives.
    assign mealy_out = (mealy_state == M_ONE_ZERO) && shift.new_bit;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            moore_state <= S_IDLE;
            mealy_state <= M_IDLE;
        end else if (shift.strobe) begin
            moore_state <= moore_next;
            mealy_state <= mealy_next;
        end
    end

    // Moore count trails by one strobe, it sees S_HIT a strobe later.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            moore_hits <= '0;
            mealy_hits <= '0;
        end else if (shift.strobe) begin
            if (moore_out) begin
                moore_hits <= moore_hits + 1'b1;
            end
            if (mealy_out) begin
                mealy_hits <= mealy_hits + 1'b1;
            end
        end
    end

    assign cnt.moore_hits  = moore_hits;
    assign cnt.mealy_hits  = mealy_hits;
    assign cnt.shift_count = shift.shift_count;  // Passed on for the display.
    assign cnt.word        = shift.word;

endmodule

/* verilog/display_scan.sv */
`timescale 1ns/10ps

module display_scan import seq_demo_pkg::*; #(
    parameter int DEBOUNCE_DEPTH   = 8,
    parameter int SEG_STROBE_WIDTH = 10
) (
    input  logic       clk,
    input  logic       i_arst_n,
    input  logic [7:0] i_sw,
    count_if.dst       cnt,
    output logic [7:0] o_abcdefgh,
    output logic [7:0] o_digit
);

    logic [7:0] sw_db;
    logic       seg_strobe;
    logic [2:0] digit_idx;
    disp_word_t disp_word;
    logic [3:0] nibble;
    seg_t       seg_on;

    sync_and_debounce #(
        .W     (8),
        .DEPTH (DEBOUNCE_DEPTH)
    ) u_sw_debounce (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_in     (i_sw),
        .o_out    (sw_db)
    );

    strobe_gen #(
        .W (SEG_STROBE_WIDTH)
    ) u_seg_strobe (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .o_strobe (seg_strobe)
    );

    // Switch 0 picks the counters or the raw shift register.
    assign disp_word = sw_db[0] ? disp_word_t'(cnt.word)
                                : {cnt.shift_count, cnt.moore_hits, cnt.mealy_hits};

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            digit_idx <= '0;
        end else if (seg_strobe) begin
            digit_idx <= digit_idx + 1'b1;  // 0 up to 7, then wrap.
        end
    end

    assign nibble = disp_word[digit_idx*4 +: 4];

    // Hex decode, active high here, a in the top bit.
    always_comb begin
        case (nibble)
            4'h0:    seg_on = 7'b1111110;
            4'h1:    seg_on = 7'b0110000;
            4'h2:    seg_on = 7'b1101101;
            4'h3:    seg_on = 7'b1111001;
            4'h4:    seg_on = 7'b0110011;
            4'h5:    seg_on = 7'b1011011;
            4'h6:    seg_on = 7'b1011111;
            4'h7:    seg_on = 7'b1110000;
            4'h8:    seg_on = 7'b1111111;
            4'h9:    seg_on = 7'b1111011;
            4'ha:    seg_on = 7'b1110111;
            4'hb:    seg_on = 7'b0011111;
            4'hc:    seg_on = 7'b1001110;
            4'hd:    seg_on = 7'b0111101;
            4'he:    seg_on = 7'b1001111;
            default: seg_on = 7'b1000111;
        endcase
    end

    // Segments and dot are active low, dot k follows switch k.
    assign o_abcdefgh = {~seg_on, ~sw_db[digit_idx]};
    assign o_digit    = ~(8'b0000_0001 << digit_idx);  // One anode low.

endmodule

/* verilog/seq_demo_top.sv */
`timescale 1ns/10ps

module seq_demo_top #(
    parameter int DEBOUNCE_DEPTH     = 8,
    parameter int SHIFT_STROBE_WIDTH = 23,
    parameter int SEG_STROBE_WIDTH   = 10
) (
    input  logic        clk,
    input  logic        i_arst_n,
    input  logic        i_shift_bit,
    input  logic [ 7:0] i_sw,
    output logic [11:0] o_led,
    output logic [ 7:0] o_abcdefgh,
    output logic [ 7:0] o_digit
);

    shift_if u_shift_if ();
    count_if u_count_if ();

    // Debounce, strobe and shift.
    shift_stage #(
        .DEBOUNCE_DEPTH     (DEBOUNCE_DEPTH),
        .SHIFT_STROBE_WIDTH (SHIFT_STROBE_WIDTH)
    ) u_shift_stage (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_shift_bit (i_shift_bit),
        .o_led       (o_led),
        .shift       (u_shift_if.src)
    );

    // Moore and Mealy detectors.
    pattern_detect u_pattern_detect (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .shift    (u_shift_if.dst),
        .cnt      (u_count_if.src)
    );

    // Seven-segment scan.
    display_scan #(
        .DEBOUNCE_DEPTH   (DEBOUNCE_DEPTH),
        .SEG_STROBE_WIDTH (SEG_STROBE_WIDTH)
    ) u_display_scan (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_sw       (i_sw),
        .cnt        (u_count_if.dst),
        .o_abcdefgh (o_abcdefgh),
        .o_digit    (o_digit)
    );

endmodule

/* sim/seq_demo_chk.sv */
`timescale 1ns/10ps

module seq_demo_chk (
    input logic        clk,
    input logic        i_arst_n,
    input logic [11:0] i_led,
    input logic [ 7:0] i_digit,
    input logic        i_shift_strobe
);

    logic seen_strobe;
    int   fail_count = 0;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            seen_strobe <= 1'b0;
        end else if (i_shift_strobe) begin
            seen_strobe <= 1'b1;  // First shift has happened.
        end
    end

    a_one_anode: assert property (@(posedge clk) disable iff (!i_arst_n)
        $onehot(~i_digit))
        else begin
            fail_count++;
            $error("o_digit does not have exactly one active anode");
        end

    a_leds_off: assert property (@(posedge clk) disable iff (!i_arst_n)
        (!seen_strobe && !i_shift_strobe) |-> (i_led == 12'hfff))
        else begin
            fail_count++;
            $error("o_led changed before the first shift strobe");
        end

    // Anode moves one place up and wraps from digit 7 to digit 0.
    a_digit_step: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_digit != $past(i_digit)) |->
        (i_digit == (($past(i_digit) << 1) | ($past(i_digit) >> 7))))
        else begin
            fail_count++;
            $error("o_digit jumped to a digit other than the next one");
        end

endmodule

bind seq_demo_top seq_demo_chk u_chk (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_led          (o_led),
    .i_digit        (o_digit),
    .i_shift_strobe (u_shift_if.strobe)
);

/* sim/tb_seq_demo.sv */
`timescale 1ns/10ps

module tb_seq_demo import seq_demo_pkg::*; ();

    localparam int WINDOW     = 32;  // Cycles between shift strobes.
    localparam int N_RANDOM   = 60;
    localparam int N_WINDOWS  = 1 + N_RANDOM + 2 + 11 + 6 + 4 * 2;
    localparam int TIMEOUT_NS = (N_WINDOWS * WINDOW + 200) * 10;

    logic         clk;
    logic         i_arst_n;
    logic         i_shift_bit;
    logic [ 7:0]  i_sw;
    logic [11:0]  o_led;
    logic [ 7:0]  o_abcdefgh;
    logic [ 7:0]  o_digit;
    logic [31:0]  seed = 32'ha42443fc;
    int           errors;
    int           test_errors;
    int           tests_run;
    int           tests_failed;
    shift_word_t  m_word;
    shift_count_t m_count;
    hit_count_t   m_moore;
    hit_count_t   m_mealy;
    logic [2:0]   m_hist;    // Last three shifted bits with the newest at 0.
    logic         cur_bit;   // Level held on i_shift_bit.
    disp_word_t   got_word;
    logic [7:0]   got_dots;

    seq_demo_top #(
        .DEBOUNCE_DEPTH     (2),
        .SHIFT_STROBE_WIDTH (5),
        .SEG_STROBE_WIDTH   (2)
    ) DUT (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_shift_bit (i_shift_bit),
        .i_sw        (i_sw),
        .o_led       (o_led),
        .o_abcdefgh  (o_abcdefgh),
        .o_digit     (o_digit)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic random_bit();
        logic [31:0] r;
        r = lcg_next();
        return r[16];  // Upper bits have the longer period.
    endfunction

    // Active low with segment a in bit 6.
    function automatic logic [6:0] seg_pattern(input logic [3:0] nib);
        case (nib)
            4'h0: return 7'h01;
            4'h1: return 7'h4f;
            4'h2: return 7'h12;
            4'h3: return 7'h06;
            4'h4: return 7'h4c;
            4'h5: return 7'h24;
            4'h6: return 7'h20;
            4'h7: return 7'h0f;
            4'h8: return 7'h00;
            4'h9: return 7'h04;
            4'ha: return 7'h08;
            4'hb: return 7'h60;
            4'hc: return 7'h31;
            4'hd: return 7'h42;
            4'he: return 7'h30;
            default: return 7'h38;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // One model shift with the Moore count one strobe late.
    task automatic model_shift(input logic b);
        if (m_hist == 3'b101) begin
            m_moore++;
        end
        if (m_hist[1:0] == 2'b10 && b) begin
            m_mealy++;
        end
        m_hist  = {m_hist[1:0], b};
        m_word  = {m_word[10:0], b};
        m_count = m_count + 1'b1;
    endtask

    // Starts and ends just after a shift edge.
    task automatic shift_window(input logic b, input logic [7:0] sw);
        step(4);
        i_shift_bit = b;
        i_sw        = sw;
        cur_bit     = b;
        step(WINDOW - 4);
        model_shift(b);
        check("o_led", o_led, shift_word_t'(~m_word));
    endtask

    task automatic read_digit();
        int k;
        bit found;
        k     = -1;
        found = 0;
        for (int i = 0; i < 8; i++) begin
            if (!o_digit[i]) begin
                k = i;
            end
        end
        if (k < 0) begin
            errors++;
            $display("no digit anode is active while scanning");
        end else begin
            for (int v = 0; v < 16; v++) begin
                if (o_abcdefgh[7:1] == seg_pattern(v[3:0])) begin
                    got_word[k*4 +: 4] = v[3:0];
                    found              = 1;
                end
            end
            if (!found) begin
                errors++;
                $display("digit %0d shows a segment pattern that is no hex digit", k);
            end
            got_dots[k] = ~o_abcdefgh[0];
        end
    endtask

    // Reads all eight digits between two shift edges.
    task automatic scan_window();
        int         used;
        logic [7:0] prev;
        got_word = 'x;
        got_dots = 'x;
        step(1);  // Counters settle.
        used = 1;
        for (int n = 0; n < 8; n++) begin
            prev = o_digit;
            read_digit();
            while (n < 7 && o_digit == prev) begin
                step(1);
                used++;
            end
        end
        step(WINDOW - used);
        model_shift(cur_bit);
        check("o_led", o_led, shift_word_t'(~m_word));
    endtask

    initial begin
        #(TIMEOUT_NS * 1ns);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int         k;
        logic [7:0] sw;
        disp_word_t exp_word;
        clk          = 1'b0;
        i_arst_n     = 1'b0;
        i_shift_bit  = 1'b0;
        i_sw         = '0;
        m_word       = '0;
        m_count      = '0;
        m_moore      = '0;
        m_mealy      = '0;
        m_hist       = '0;
        cur_bit      = 1'b0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        #1;
        i_arst_n = 1'b1;

        check("o_led", o_led, 32'hfff);
        check("o_digit", o_digit, 32'hfe);
        check("o_abcdefgh", o_abcdefgh, {seg_pattern(4'h0), 1'b1});
        end_test("reset values");

        step(WINDOW);  // First strobe takes the reset-time 0.
        model_shift(1'b0);
        for (int i = 0; i < N_RANDOM; i++) begin
            shift_window(random_bit(), 8'h00);
        end
        end_test("random shifts on leds");

        shift_window(random_bit(), 8'h01);
        exp_word = disp_word_t'(m_word);
        scan_window();
        check("disp_word", got_word, exp_word);
        end_test("shift register on display");

        for (int i = 0; i < 10; i++) begin
            shift_window(random_bit(), 8'h00);
        end
        exp_word = {m_count, m_moore, m_mealy};
        scan_window();
        check("disp_word", got_word, exp_word);
        end_test("counts on display");

        for (int i = 0; i < 5; i++) begin
            shift_window(~i[0], 8'h00);  // 1-0-1-0-1.
        end
        exp_word = {m_count, m_moore, m_mealy};
        scan_window();
        check("disp_word", got_word, exp_word);
        check("mealy_minus_moore", hit_count_t'(got_word[7:0] - got_word[15:8]), 32'h1);
        end_test("overlapping hits");

        for (int i = 0; i < 4; i++) begin
            k  = 1 + lcg_next() % 7;
            sw = 8'h01 << k;
            shift_window(random_bit(), sw);
            exp_word = {m_count, m_moore, m_mealy};
            scan_window();
            check("dots", got_dots, sw);
            check("disp_word", got_word, exp_word);
        end
        end_test("switch dots");

        check("u_chk.fail_count", DUT.u_chk.fail_count, 32'h0);
        end_test("bound assertions");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* seq_demo_top.f */
verilog/seq_demo_pkg.sv
verilog/stage_if.sv
verilog/sync_and_debounce.sv
verilog/strobe_gen.sv
verilog/shift_stage.sv
verilog/pattern_detect.sv
verilog/display_scan.sv
verilog/seq_demo_top.sv
sim/seq_demo_chk.sv
sim/tb_seq_demo.sv

/* Bender.yml */
package:
  name: seq_demo

sources:
  - verilog/seq_demo_pkg.sv
  - verilog/stage_if.sv
  - verilog/sync_and_debounce.sv
  - verilog/strobe_gen.sv
  - verilog/shift_stage.sv
  - verilog/pattern_detect.sv
  - verilog/display_scan.sv
  - verilog/seq_demo_top.sv
  - target: simulation
    files:
      - sim/seq_demo_chk.sv
      - sim/tb_seq_demo.sv
